// ==== bench/spi_link_tb.sv ====
// Testbench for the SPI link top level with the Wishbone port as the only control path.
// Runs reset, register, single, random, dropped-write and chip-select transfers.
`timescale 1ns/10ps
`default_nettype none

`include "spi_params.svh"

module spi_link_tb;
	import spi_pkg::*;

	localparam int ACK_TIMEOUT = 50;     // cycles to wait for wb_ack
	localparam int POLL_LIMIT  = 1000;   // status reads before giving up
	localparam int CS_TIMEOUT  = 50;
	localparam int RX_TIMEOUT  = 200;    // cycles for the slave byte

	logic      sys_clk;
	logic      arst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	wb_adr_t   wb_adr;
	wb_data_t  wb_wdata;
	wb_data_t  wb_rdata;
	logic      wb_ack;
	spi_data_t slave_tx;
	spi_data_t slave_rx;
	logic      slave_rx_valid;
	logic      spi_cs_n;
	logic      spi_sclk;

	integer    seed;
	spi_data_t exp_slave_q[$];   // bytes the slave should report
	spi_data_t exp_master;       // byte RXDATA should hold

	spi_link_top u_spi_link_top (
		.sys_clk        (sys_clk),
		.arst_n         (arst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_wdata       (wb_wdata),
		.wb_rdata       (wb_rdata),
		.wb_ack         (wb_ack),
		.slave_tx       (slave_tx),
		.slave_rx       (slave_rx),
		.slave_rx_valid (slave_rx_valid),
		.spi_cs_n       (spi_cs_n),
		.spi_sclk       (spi_sclk)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;   // 50 MHz
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_data(input string name, input spi_data_t got, input spi_data_t exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// master result is the slave's byte, slave result is the TXDATA byte
	function automatic logic [2*`SPI_DATA_W-1:0] expected_pair(input spi_data_t tx_byte,
			input spi_data_t slv_byte);
		return {slv_byte, tx_byte};   // {master rxdata, slave_rx}
	endfunction

	// one classic cycle, held until ack
	task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdata,
			output wb_data_t rdata);
		int n;
		n = 0;
		@(negedge sys_clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = wdata;
		do begin
			@(negedge sys_clk);
			n++;
			if (n > ACK_TIMEOUT)
				stop_run("Timeout: wb_ack never came for a Wishbone cycle");
		end while (!wb_ack);
		rdata  = wb_rdata;   // valid with ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
		wb_data_t unused;
		wb_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
		wb_cycle(1'b0, adr, '0, data);
	endtask

	task automatic wait_cs(input logic level);
		int n;
		n = 0;
		while (spi_cs_n !== level) begin
			@(negedge sys_clk);
			n++;
			if (n > CS_TIMEOUT)
				stop_run("Timeout: spi_cs_n never reached the expected level");
		end
	endtask

	task automatic start_transfer(input spi_data_t tx_byte, input spi_data_t slv_byte,
			input spi_div_t div);
		logic [2*`SPI_DATA_W-1:0] pair;
		pair = expected_pair(tx_byte, slv_byte);
		@(negedge sys_clk);
		slave_tx = slv_byte;                   // held until the transfer ends
		wb_write(`REG_DIV, wb_data_t'(div));
		exp_master = pair[2*`SPI_DATA_W-1:`SPI_DATA_W];
		exp_slave_q.push_back(pair[`SPI_DATA_W-1:0]);
		wb_write(`REG_TXDATA, wb_data_t'(tx_byte));
	endtask

	task automatic finish_transfer();
		wb_data_t st;
		wb_data_t rd;
		int       n;
		n  = 0;
		st = '0;
		do begin
			wb_read(`REG_STATUS, st);
			n++;
			if (n > POLL_LIMIT)
				stop_run("Timeout: done bit never set in STATUS");
		end while (!st[1]);
		wb_read(`REG_RXDATA, rd);
		check_data("rxdata", rd[`SPI_DATA_W-1:0], exp_master);
		n = 0;
		while (exp_slave_q.size() != 0) begin
			@(negedge sys_clk);
			n++;
			if (n > RX_TIMEOUT)
				stop_run("Timeout: slave_rx_valid pulse never arrived");
		end
		wb_read(`REG_STATUS, st);
		check_word("status", st, 16'h0000);   // done cleared, not busy
	endtask

	task automatic run_transfer(input spi_data_t tx_byte, input spi_data_t slv_byte,
			input spi_div_t div);
		start_transfer(tx_byte, slv_byte, div);
		finish_transfer();
	endtask

	// slave side compare, sampled away from the rising edge
	initial begin
		forever begin
			@(negedge sys_clk);
			if (arst_n && slave_rx_valid) begin
				if (exp_slave_q.size() == 0)
					stop_run("slave_rx_valid pulsed with no transfer expected");
				check_data("slave_rx", slave_rx, exp_slave_q.pop_front());
			end
		end
	end

	initial begin : main_seq
		wb_data_t rd;
		seed     = 32'hba28bdfe;
		arst_n   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_wdata = '0;
		slave_tx = '0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n = 1'b1;

		// reset values
		wb_read(`REG_CTRL, rd);
		check_word("ctrl", rd, 16'h0000);
		wb_read(`REG_DIV, rd);
		check_word("div", rd, 16'd49);
		wb_read(`REG_STATUS, rd);
		check_word("status", rd, 16'h0000);
		check_bit("spi_cs_n", spi_cs_n, 1'b1);
		check_bit("spi_sclk", spi_sclk, 1'b1);   // CPOL of 1
		check_bit("slave_rx_valid", slave_rx_valid, 1'b0);

		// register readback and unmapped space
		wb_write(`REG_CTRL, 16'h0001);
		wb_read(`REG_CTRL, rd);
		check_word("ctrl", rd, 16'h0001);
		wb_write(`REG_CTRL, 16'h0000);
		wb_read(`REG_CTRL, rd);
		check_word("ctrl", rd, 16'h0000);
		wb_write(`REG_DIV, 16'h1234);
		wb_read(`REG_DIV, rd);
		check_word("div", rd, 16'h1234);
		for (int a = 5; a < 8; a++) begin
			wb_write(wb_adr_t'(a), 16'hffff);   // ignored
			wb_read(wb_adr_t'(a), rd);
			check_word("unmapped", rd, 16'h0000);
		end
		wb_read(`REG_DIV, rd);
		check_word("div", rd, 16'h1234);        // untouched by unmapped writes
		wait_cs(1'b1);

		// single transfer
		run_transfer(8'ha5, 8'h3c, 16'd3);

		// random transfers
		repeat (20) begin
			run_transfer(spi_data_t'($random(seed)), spi_data_t'($random(seed)),
				spi_div_t'(3 + ($unsigned($random(seed)) % 18)));
		end

		// second txdata write while busy is dropped
		start_transfer(8'h5a, 8'hc3, 16'd3);
		wb_write(`REG_TXDATA, 16'h00f0);
		finish_transfer();
		repeat (100) @(negedge sys_clk);        // quiet window for a stray byte

		// chip select held by cs_en
		@(negedge sys_clk);
		slave_tx = 8'h96;
		wb_write(`REG_CTRL, 16'h0001);
		wait_cs(1'b0);
		run_transfer(8'h69, 8'h96, 16'd4);
		check_bit("spi_cs_n", spi_cs_n, 1'b0);  // still low while idle
		start_transfer(8'h81, 8'h7e, 16'd5);
		wb_write(`REG_CTRL, 16'h0000);          // clear during the transfer
		check_bit("spi_cs_n", spi_cs_n, 1'b0);
		finish_transfer();
		wait_cs(1'b1);
		run_transfer(8'h24, 8'hdb, 16'd3);
		check_bit("spi_cs_n", spi_cs_n, 1'b1);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/spi_link_top.sv ====
// Top level of the SPI link with a Wishbone register port.
// Master and slave talk over internal wires; cs and sclk are brought out to watch.
`timescale 1ns/10ps
`default_nettype none

module spi_link_top #(
	parameter bit CPOL = 1'b1,   // shared by both ends
	parameter bit CPHA = 1'b1
) (
	input  logic               sys_clk,
	input  logic               arst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  spi_pkg::wb_adr_t   wb_adr,
	input  spi_pkg::wb_data_t  wb_wdata,
	output spi_pkg::wb_data_t  wb_rdata,
	output logic               wb_ack,
	input  spi_pkg::spi_data_t slave_tx,
	output spi_pkg::spi_data_t slave_rx,
	output logic               slave_rx_valid,
	output logic               spi_cs_n,
	output logic               spi_sclk
);
	import spi_pkg::*;

	logic      cs_ctrl;
	logic      wr_req;
	logic      wr_ack;
	logic      mosi;
	logic      miso;
	spi_div_t  clk_div_val;
	spi_data_t master_tx;    // txdata register to master
	spi_data_t master_rx;    // master result to rxdata

	spi_regs u_spi_regs (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdata    (wb_wdata),
		.wb_rdata    (wb_rdata),
		.wb_ack      (wb_ack),
		.cs_ctrl     (cs_ctrl),
		.clk_div_val (clk_div_val),
		.wr_req      (wr_req),
		.data_tx     (master_tx),
		.wr_ack      (wr_ack),
		.data_rx     (master_rx)
	);

	spi_master #(.CPOL(CPOL), .CPHA(CPHA)) u_spi_master (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.cs_ctrl     (cs_ctrl),
		.clk_div_val (clk_div_val),
		.wr_req      (wr_req),
		.wr_ack      (wr_ack),
		.data_tx     (master_tx),
		.data_rx     (master_rx),
		.cs          (spi_cs_n),   // also the monitor output
		.sclk        (spi_sclk),
		.mosi        (mosi),
		.miso        (miso)
	);

	spi_slave #(.CPOL(CPOL), .CPHA(CPHA)) u_spi_slave (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.cs          (spi_cs_n),
		.sclk        (spi_sclk),
		.mosi        (mosi),
		.miso        (miso),
		.data_tx     (slave_tx),
		.re_ack      (slave_rx_valid),
		.data_rx     (slave_rx)
	);

endmodule

`default_nettype wire

// ==== rtl/spi_master.sv ====
// SPI master for one full-duplex byte per request, MSB first.
// CPOL and CPHA pick the mode; clk_div_val sets the sclk half-period.
`timescale 1ns/10ps
`default_nettype none

`include "spi_params.svh"

module spi_master #(
	parameter bit CPOL = 1'b1,   // idle level of sclk
	parameter bit CPHA = 1'b1    // 0 samples on leading edge, 1 on trailing
) (
	input  logic               sys_clk,
	input  logic               arst_n,
	input  logic               cs_ctrl,
	input  spi_pkg::spi_div_t  clk_div_val,
	input  logic               wr_req,
	output logic               wr_ack,
	input  spi_pkg::spi_data_t data_tx,
	output spi_pkg::spi_data_t data_rx,
	output logic               cs,
	output logic               sclk,
	output logic               mosi,
	input  logic               miso
);
	import spi_pkg::*;

	localparam int                EDGE_W    = $clog2(2 * `SPI_DATA_W);
	localparam logic [EDGE_W-1:0] EDGE_LAST = EDGE_W'(2 * `SPI_DATA_W - 1);

	typedef enum logic [1:0] {
		ST_IDLE,    // waiting for wr_req
		ST_LEAD,    // cs setup before the first edge
		ST_SHIFT,   // sixteen sclk toggles
		ST_DONE     // cs hold, then ack
	} state_t;

	state_t            state;
	spi_div_t          div_cnt;     // half-period counter
	logic [EDGE_W-1:0] edge_cnt;    // even is leading, odd is trailing
	spi_data_t         tx_sr;
	spi_data_t         rx_sr;
	logic              tick;        // end of a half-period
	logic              in_shift;
	logic              samp_edge;
	logic              shift_edge;

	assign tick      = (div_cnt >= clk_div_val);
	assign in_shift  = (state == ST_SHIFT) && tick;
	assign samp_edge = in_shift && (edge_cnt[0] == CPHA);
	// first bit is already on mosi, so edge 0 never shifts
	assign shift_edge = in_shift && (edge_cnt[0] != CPHA) && (edge_cnt != '0);
	assign mosi       = tx_sr[`SPI_DATA_W-1];

	// divider runs only during a transfer
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			div_cnt <= '0;
		else if ((state == ST_IDLE) || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// FSM and sclk generation
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			edge_cnt <= '0;
			sclk     <= CPOL;
			wr_ack   <= 1'b0;
		end else begin
			wr_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wr_req)
						state <= ST_LEAD;
				end
				ST_LEAD: begin
					if (tick)
						state <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (tick) begin
						sclk     <= ~sclk;
						edge_cnt <= edge_cnt + 1'b1;   // wraps to 0 after last edge
						if (edge_cnt == EDGE_LAST)
							state <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (tick) begin
						wr_ack <= 1'b1;                // data_rx valid with it
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// chip select, active low
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			cs <= 1'b1;
		else
			cs <= !(cs_ctrl || wr_req || (state != ST_IDLE));
	end

	// shift registers
	always_ff @(posedge sys_clk) begin
		if ((state == ST_IDLE) && wr_req)
			tx_sr <= data_tx;
		else if (shift_edge)
			tx_sr <= {tx_sr[`SPI_DATA_W-2:0], 1'b0};
		if (samp_edge)
			rx_sr <= {rx_sr[`SPI_DATA_W-2:0], miso};
		if ((state == ST_DONE) && tick)
			data_rx <= rx_sr;
	end

	// register block must hold requests while a transfer runs
	a_req_when_idle: assert property (
		@(posedge sys_clk) disable iff (!arst_n)
		wr_req |-> (state == ST_IDLE)
	) else $error("wr_req arrived while master busy");

endmodule

`default_nettype wire

// ==== rtl/spi_params.svh ====
// Widths, register map and reset values shared by the SPI link.
// Included by the package and by every module that needs a constant.
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

`define SPI_DATA_W   8      // one spi byte
`define SPI_DIV_W    16     // sclk divider width
`define WB_ADR_W     3      // wishbone word address
`define WB_DAT_W     16     // wishbone data word

`define SPI_DIV_RST  16'd49 // divider after reset
`define SPI_DIV_MIN  3      // lowest divider the slave can oversample

`define REG_CTRL     3'd0   // bit 0 cs_en
`define REG_DIV      3'd1   // sclk half-period minus one
`define REG_TXDATA   3'd2   // write starts a transfer
`define REG_RXDATA   3'd3   // read clears done
`define REG_STATUS   3'd4   // bit 0 busy, bit 1 done

`endif

// ==== rtl/spi_pkg.sv ====
// Shared vector types of the SPI link.
// Compile first; modules import it in their bodies.
`default_nettype none

`include "spi_params.svh"

package spi_pkg;

	// one byte on the spi wires
	typedef logic [`SPI_DATA_W-1:0] spi_data_t;

	// sclk half-period minus one, in sys_clk cycles
	typedef logic [`SPI_DIV_W-1:0] spi_div_t;

	// wishbone word address
	typedef logic [`WB_ADR_W-1:0] wb_adr_t;

	// wishbone data word
	typedef logic [`WB_DAT_W-1:0] wb_data_t;

endpackage

`default_nettype wire

// ==== rtl/spi_regs.sv ====
// Wishbone classic register block beside the SPI master.
// Holds CTRL, DIV and TXDATA, captures RXDATA and starts one transfer at a time.
`timescale 1ns/10ps
`default_nettype none

`include "spi_params.svh"

module spi_regs (
	input  logic               sys_clk,
	input  logic               arst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  spi_pkg::wb_adr_t   wb_adr,
	input  spi_pkg::wb_data_t  wb_wdata,
	output spi_pkg::wb_data_t  wb_rdata,
	output logic               wb_ack,
	output logic               cs_ctrl,
	output spi_pkg::spi_div_t  clk_div_val,
	output logic               wr_req,
	output spi_pkg::spi_data_t data_tx,
	input  logic               wr_ack,
	input  spi_pkg::spi_data_t data_rx
);
	import spi_pkg::*;

	logic      acc;    // first cycle of a bus access
	logic      tx_go;  // txdata write accepted
	logic      busy;   // request issued, no ack yet
	logic      done;   // sticky until rxdata read
	spi_data_t rx_q;   // last received byte

	assign acc   = wb_cyc && wb_stb && !wb_ack;
	assign tx_go = acc && wb_we && (wb_adr == `REG_TXDATA) && !busy;

	// control state
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack      <= 1'b0;
			cs_ctrl     <= 1'b0;
			clk_div_val <= `SPI_DIV_RST;
			wr_req      <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
		end else begin
			wb_ack <= acc;         // single-cycle ack
			wr_req <= tx_go;       // one pulse per accepted write
			if (acc && wb_we) begin
				case (wb_adr)
					`REG_CTRL: cs_ctrl     <= wb_wdata[0];
					`REG_DIV:  clk_div_val <= spi_div_t'(wb_wdata);
					default:   ;       // txdata handled by tx_go
				endcase
			end
			if (tx_go)
				busy <= 1'b1;
			if (acc && !wb_we && (wb_adr == `REG_RXDATA))
				done <= 1'b0;      // read of rxdata clears done
			if (wr_ack) begin
				busy <= 1'b0;
				done <= 1'b1;      // set wins over a same-cycle clear
			end
		end
	end

	// byte to send, stable while wr_req is high
	always_ff @(posedge sys_clk) begin
		if (tx_go)
			data_tx <= wb_wdata[`SPI_DATA_W-1:0];
		if (wr_ack)
			rx_q <= data_rx;       // master result
	end

	// read mux, registered so data lines up with wb_ack
	always_ff @(posedge sys_clk) begin
		if (acc) begin
			case (wb_adr)
				`REG_CTRL:   wb_rdata <= wb_data_t'(cs_ctrl);
				`REG_DIV:    wb_rdata <= wb_data_t'(clk_div_val);
				`REG_TXDATA: wb_rdata <= wb_data_t'(data_tx);
				`REG_RXDATA: wb_rdata <= wb_data_t'(rx_q);
				`REG_STATUS: wb_rdata <= wb_data_t'({done, busy});
				default:     wb_rdata <= '0;   // unmapped reads zero
			endcase
		end
	end

	// master acks only a request this block issued
	property p_ack_only_when_busy;
		@(posedge sys_clk) disable iff (!arst_n)
		wr_ack |-> busy;
	endproperty
	a_ack_only_when_busy: assert property (p_ack_only_when_busy)
		else $error("wr_ack arrived with no transfer pending");

endmodule

`default_nettype wire

// ==== rtl/spi_slave.sv ====
// SPI slave clocked by sys_clk that oversamples sclk, cs and mosi.
// Answers each byte with data_tx and pulses re_ack with the received byte.
`timescale 1ns/10ps
`default_nettype none

`include "spi_params.svh"

module spi_slave #(
	parameter bit CPOL = 1'b1,   // idle level of sclk
	parameter bit CPHA = 1'b1    // must match the master
) (
	input  logic               sys_clk,
	input  logic               arst_n,
	input  logic               cs,
	input  logic               sclk,
	input  logic               mosi,
	output logic               miso,
	input  spi_pkg::spi_data_t data_tx,
	output logic               re_ack,
	output spi_pkg::spi_data_t data_rx
);
	import spi_pkg::*;

	localparam int               BIT_W    = $clog2(`SPI_DATA_W);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_DATA_W - 1);

	logic [2:0]       sclk_s;     // two sync flops plus last value
	logic [2:0]       cs_s;
	logic [1:0]       mosi_s;
	logic             sclk_edge;
	logic             lead_edge;  // away from idle level
	logic             trail_edge; // back to idle level
	logic             cs_act;
	logic             cs_fall;
	logic             samp_stb;
	logic             shift_stb;
	logic [BIT_W-1:0] bit_cnt;
	spi_data_t        tx_sr;
	spi_data_t        rx_sr;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_s <= {3{CPOL}};
			cs_s   <= '1;
			mosi_s <= '0;
		end else begin
			sclk_s <= {sclk_s[1:0], sclk};
			cs_s   <= {cs_s[1:0], cs};
			mosi_s <= {mosi_s[0], mosi};   // same delay as sclk_s[1]
		end
	end

	assign sclk_edge  = sclk_s[2] ^ sclk_s[1];
	assign lead_edge  = sclk_edge && (sclk_s[2] == CPOL);
	assign trail_edge = sclk_edge && (sclk_s[1] == CPOL);
	assign cs_act     = !cs_s[1];
	assign cs_fall    = cs_s[2] && !cs_s[1];
	assign samp_stb   = cs_act && (CPHA ? trail_edge : lead_edge);
	assign shift_stb  = cs_act && (CPHA ? lead_edge : trail_edge);
	assign miso       = tx_sr[`SPI_DATA_W-1];

	// bit counter and byte strobe
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			re_ack  <= 1'b0;
		end else begin
			re_ack <= samp_stb && (bit_cnt == BIT_LAST);
			if (!cs_act)
				bit_cnt <= '0;                 // realign on deselect
			else if (samp_stb)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// reload at cs fall and on the first shift edge of each byte
	always_ff @(posedge sys_clk) begin
		if (cs_fall || (shift_stb && (bit_cnt == '0)))
			tx_sr <= data_tx;
		else if (shift_stb)
			tx_sr <= {tx_sr[`SPI_DATA_W-2:0], 1'b0};
		if (samp_stb)
			rx_sr <= {rx_sr[`SPI_DATA_W-2:0], mosi_s[1]};
		if (samp_stb && (bit_cnt == BIT_LAST))
			data_rx <= {rx_sr[`SPI_DATA_W-2:0], mosi_s[1]};
	end

	// a faster sclk than the divider floor breaks the oversampling
	a_sclk_spacing: assert property (
		@(posedge sys_clk) disable iff (!arst_n)
		sclk_edge |=> !sclk_edge [*(`SPI_DIV_MIN - 1)]
	) else $error("sclk edges too close for the slave synchronizer");

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_regs.sv
rtl/spi_master.sv
rtl/spi_slave.sv
rtl/spi_link_top.sv
bench/spi_link_tb.sv
